/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int ilen = 32;
    localparam int alen = 32;
    localparam int xlen = 32;

    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LOAD      = 5'b00_000,
        MISC_MEM  = 5'b00_011,
        OP_IMM    = 5'b00_100,
        AUIPC     = 5'b00_101,
        OP_IMM_32 = 5'b00_110,
        STORE     = 5'b01_000,
        OP        = 5'b01_100,
        LUI       = 5'b01_101,
        OP_32     = 5'b01_110,
        BRANCH    = 5'b11_000,
        JALR      = 5'b11_001,
        JAL       = 5'b11_011,
        SYSTEM    = 5'b11_100
    } opcode_e;

    // listed in priority order, highest first after none
    typedef enum logic [1:0] {
        none           = 2'd0,
        fetch_fault    = 2'd1,
        compressed     = 2'd2,
        illegal_opcode = 2'd3
    } exc_cause_e;

endpackage

`default_nettype wire

/* rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    // fetch to decode, 98 bits
    typedef struct packed {
        logic                          valid;
        logic                          fetch_fault;
        logic [rv_isa_pkg::ilen-1:0]   instr;
        logic [rv_isa_pkg::alen-1:0]   pc;
        logic [rv_isa_pkg::alen-1:0]   next_pc;
    } fetch_pkt_t;

    // forwarding source, 38 bits
    typedef struct packed {
        logic                             valid;
        logic [rv_isa_pkg::reg_idx_w-1:0] idx;
        logic [rv_isa_pkg::xlen-1:0]      data;
    } bypass_t;

    // writeback command doubles as the late bypass
    typedef bypass_t wb_t;

    typedef struct packed {
        logic                             valid;
        logic                             exception;
        rv_isa_pkg::exc_cause_e           cause;
        logic                             is_compressed;
        logic                             is_jump;
        logic                             is_reg_write;
        logic [rv_isa_pkg::alen-1:0]      pc;
        logic [rv_isa_pkg::alen-1:0]      next_pc;
        rv_isa_pkg::opcode_e              opcode;
        logic [rv_isa_pkg::reg_idx_w-1:0] rd;
        logic [2:0]                       funct3;
        logic [rv_isa_pkg::reg_idx_w-1:0] rs1;
        logic [rv_isa_pkg::reg_idx_w-1:0] rs2;
        logic [6:0]                       funct7;
        logic [rv_isa_pkg::xlen-1:0]      rs1_data;
        logic [rv_isa_pkg::xlen-1:0]      rs2_data;
        logic [11:0]                      i_imm;   // instr[31:20]
        logic [11:0]                      s_imm;
        logic [19:0]                      u_imm;   // instr[31:12]
        logic [19:0]                      j_imm;   // imm[20:1]
    } decode_pkt_t;

endpackage

`default_nettype wire

/* rv_skid_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_skid_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,
    input  wire rv_pipe_pkg::fetch_pkt_t fetch_in,
    input  wire                          next_stalled,
    output rv_pipe_pkg::fetch_pkt_t      skid_out,
    output logic                         stall_prev,
    output logic                         stall_next
);

    rv_pipe_pkg::fetch_pkt_t buf_q;
    logic                    full_q;
    logic                    buf_we;
    logic                    buf_rd;

    // capture only a packet that fetch handed over while decode is held
    assign buf_we = next_stalled && !full_q && fetch_in.valid && !flush;
    // decode takes the buffered packet once the hold drops
    assign buf_rd = full_q && !next_stalled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (flush) begin
            full_q <= 1'b0;
        end else if (buf_we) begin
            full_q <= 1'b1;
        end else if (buf_rd) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            buf_q <= fetch_in;
        end
    end

    assign skid_out   = full_q ? buf_q : fetch_in;
    assign stall_prev = full_q;          // fetch holds its packet while we are full
    assign stall_next = next_stalled;

    // a new packet while full would have nowhere to go
    a_fetch_holds_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_prev |=> $stable(fetch_in)
    );

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire rv_pipe_pkg::wb_t                 wb,
    input  wire [rv_isa_pkg::reg_idx_w-1:0]       rs1_sel,
    input  wire [rv_isa_pkg::reg_idx_w-1:0]       rs2_sel,
    output logic [rv_isa_pkg::xlen-1:0]           rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]           rs2_data
);

    // x0 has no storage
    logic [rv_isa_pkg::xlen-1:0] regs [1:rv_isa_pkg::reg_count-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // old value during a same-cycle write, the writeback bypass covers it
    always_comb begin
        if (rs1_sel == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_sel];
        end
    end

    always_comb begin
        if (rs2_sel == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_sel];
        end
    end

endmodule

`default_nettype wire

/* rv_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decode_stage (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              flush,
    input  wire                              hold,
    input  wire rv_pipe_pkg::fetch_pkt_t     skid_out,
    input  wire rv_pipe_pkg::bypass_t        exec_bypass,
    input  wire rv_pipe_pkg::wb_t            wb,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rs1_sel,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rs2_sel,
    input  wire [rv_isa_pkg::xlen-1:0]       rs1_data,
    input  wire [rv_isa_pkg::xlen-1:0]       rs2_data,
    output rv_pipe_pkg::decode_pkt_t         dec_out
);

    logic [rv_isa_pkg::ilen-1:0] instr;
    logic [4:0]                  op_raw;
    logic                        op_known;
    rv_pipe_pkg::decode_pkt_t    next_pkt;
    rv_pipe_pkg::decode_pkt_t    pkt_q;
    logic                        valid_q;

    // index 0, then exec, then writeback, then the array
    function automatic logic [rv_isa_pkg::xlen-1:0] pick_operand(
        input logic [rv_isa_pkg::reg_idx_w-1:0] idx,
        input logic [rv_isa_pkg::xlen-1:0]      rf_data,
        input rv_pipe_pkg::bypass_t             ex,
        input rv_pipe_pkg::wb_t                 wr
    );
        if (idx == '0)
            return '0;
        if (ex.valid && ex.idx == idx)
            return ex.data;
        if (wr.valid && wr.idx == idx)
            return wr.data;
        return rf_data;
    endfunction

    assign instr   = skid_out.instr;
    assign op_raw  = instr[6:2];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    always_comb begin
        case (op_raw)
            rv_isa_pkg::LOAD, rv_isa_pkg::MISC_MEM, rv_isa_pkg::OP_IMM,
            rv_isa_pkg::AUIPC, rv_isa_pkg::OP_IMM_32, rv_isa_pkg::STORE,
            rv_isa_pkg::OP, rv_isa_pkg::LUI, rv_isa_pkg::OP_32,
            rv_isa_pkg::BRANCH, rv_isa_pkg::JALR, rv_isa_pkg::JAL,
            rv_isa_pkg::SYSTEM: op_known = 1'b1;
            default:            op_known = 1'b0;
        endcase
    end

    always_comb begin
        next_pkt.valid   = skid_out.valid;
        next_pkt.pc      = skid_out.pc;
        next_pkt.next_pc = skid_out.next_pc;
        next_pkt.opcode  = rv_isa_pkg::opcode_e'(op_raw);
        next_pkt.rd      = instr[11:7];
        next_pkt.funct3  = instr[14:12];
        next_pkt.rs1     = instr[19:15];
        next_pkt.rs2     = instr[24:20];
        next_pkt.funct7  = instr[31:25];

        next_pkt.i_imm = instr[31:20];
        next_pkt.s_imm = {instr[31:25], instr[11:7]};
        next_pkt.u_imm = instr[31:12];
        next_pkt.j_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};

        if (skid_out.fetch_fault)
            next_pkt.cause = rv_isa_pkg::fetch_fault;
        else if (instr[1:0] != 2'b11)
            next_pkt.cause = rv_isa_pkg::compressed;   // no RVC decoder
        else if (!op_known)
            next_pkt.cause = rv_isa_pkg::illegal_opcode;
        else
            next_pkt.cause = rv_isa_pkg::none;
        next_pkt.exception = (next_pkt.cause != rv_isa_pkg::none);

        next_pkt.is_compressed = (instr[1:0] != 2'b11);
        next_pkt.is_jump       = (instr[6:5] == 2'b11);   // branch, jal, jalr, system
        next_pkt.is_reg_write  = op_raw != rv_isa_pkg::STORE
                              && op_raw != rv_isa_pkg::BRANCH
                              && op_raw != rv_isa_pkg::SYSTEM
                              && op_raw != rv_isa_pkg::MISC_MEM
                              && !next_pkt.exception;

        next_pkt.rs1_data = pick_operand(rs1_sel, rs1_data, exec_bypass, wb);
        next_pkt.rs2_data = pick_operand(rs2_sel, rs2_data, exec_bypass, wb);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= skid_out.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            pkt_q <= next_pkt;
        end
    end

    always_comb begin
        dec_out       = pkt_q;
        dec_out.valid = valid_q;
    end

    // a packet we cannot take yet has to wait on our input
    a_held_input_kept: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hold && skid_out.valid && !flush) |=> $stable(skid_out)
    );

endmodule

`default_nettype wire

/* rv_decode_front.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decode_front (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           flush,
    input  wire rv_pipe_pkg::fetch_pkt_t  fetch_in,
    input  wire                           next_stalled,
    input  wire rv_pipe_pkg::bypass_t     exec_bypass,
    input  wire rv_pipe_pkg::wb_t         wb,
    output wire                           stall_prev,
    output wire rv_pipe_pkg::decode_pkt_t dec_out
);

    wire rv_pipe_pkg::fetch_pkt_t         skid_out;
    wire                                  stall_next;
    wire [rv_isa_pkg::reg_idx_w-1:0]      rs1_sel;
    wire [rv_isa_pkg::reg_idx_w-1:0]      rs2_sel;
    wire [rv_isa_pkg::xlen-1:0]           rs1_data;
    wire [rv_isa_pkg::xlen-1:0]           rs2_data;

    rv_skid_stage u_skid (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_in     (fetch_in),
        .next_stalled (next_stalled),
        .skid_out     (skid_out),
        .stall_prev   (stall_prev),
        .stall_next   (stall_next)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // hold comes from the skid stage, which owns the stall decision
    rv_decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .hold        (stall_next),
        .skid_out    (skid_out),
        .exec_bypass (exec_bypass),
        .wb          (wb),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec_out     (dec_out)
    );

endmodule

`default_nettype wire

/* tb_rv_decode_front.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_decode_front;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    logic                     next_stalled;
    rv_pipe_pkg::fetch_pkt_t  fetch_in;
    rv_pipe_pkg::bypass_t     exec_bypass;
    rv_pipe_pkg::wb_t         wb;
    logic                     stall_prev;
    rv_pipe_pkg::decode_pkt_t dec_out;

    logic [rv_isa_pkg::xlen-1:0] shadow [rv_isa_pkg::reg_count];   // mirror of the register file
    rv_pipe_pkg::decode_pkt_t    exp_q [$];
    rv_pipe_pkg::decode_pkt_t    prev_dec;
    rv_pipe_pkg::decode_pkt_t    direct_pkt;
    logic prev_hold;
    logic prev_flush;
    logic prev_direct;
    logic prev_capture;
    logic prev_stall;
    logic fetch_taken;   // fetch may present a new packet
    int   stall_pct;
    int   n_checked;

    rv_decode_front dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_in     (fetch_in),
        .next_stalled (next_stalled),
        .exec_bypass  (exec_bypass),
        .wb           (wb),
        .stall_prev   (stall_prev),
        .dec_out      (dec_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic opcode_listed(input logic [4:0] raw);
        rv_isa_pkg::opcode_e e;
        e = e.first();
        for (int i = 0; i < e.num(); i++) begin
            if (raw == e)
                return 1'b1;
            e = e.next();
        end
        return 1'b0;
    endfunction

    // x0, then execute, then writeback, then the register file
    function automatic logic [31:0] expected_operand(input logic [4:0] idx);
        logic [31:0] val;
        val = shadow[idx];
        if (wb.valid && wb.idx == idx)
            val = wb.data;
        if (exec_bypass.valid && exec_bypass.idx == idx)
            val = exec_bypass.data;
        if (idx == 5'd0)
            val = '0;
        return val;
    endfunction

    function automatic rv_pipe_pkg::decode_pkt_t expected_decode(input rv_pipe_pkg::fetch_pkt_t f);
        rv_pipe_pkg::decode_pkt_t p;
        logic [31:0] ins;
        logic [20:0] jimm;
        logic [11:0] simm;
        ins = f.instr;
        p = '0;
        p.valid   = 1'b1;
        p.pc      = f.pc;
        p.next_pc = f.next_pc;
        p.opcode  = rv_isa_pkg::opcode_e'(ins[6:2]);
        p.rd      = ins[11:7];
        p.funct3  = ins[14:12];
        p.rs1     = ins[19:15];
        p.rs2     = ins[24:20];
        p.funct7  = ins[31:25];
        jimm        = '0;
        jimm[20]    = ins[31];
        jimm[19:12] = ins[19:12];
        jimm[11]    = ins[20];
        jimm[10:1]  = ins[30:21];
        simm[11:5]  = ins[31:25];
        simm[4:0]   = ins[11:7];
        p.i_imm = ins[31:20];
        p.s_imm = simm;
        p.u_imm = ins[31:12];
        p.j_imm = jimm[20:1];
        p.is_compressed = (ins[1:0] != 2'b11);
        p.is_jump       = ins[6] && ins[5];
        if (f.fetch_fault)
            p.cause = rv_isa_pkg::fetch_fault;
        else if (p.is_compressed)
            p.cause = rv_isa_pkg::compressed;
        else if (!opcode_listed(ins[6:2]))
            p.cause = rv_isa_pkg::illegal_opcode;
        else
            p.cause = rv_isa_pkg::none;
        p.exception = (p.cause != rv_isa_pkg::none);
        case (p.opcode)
            rv_isa_pkg::STORE, rv_isa_pkg::BRANCH,
            rv_isa_pkg::SYSTEM, rv_isa_pkg::MISC_MEM: p.is_reg_write = 1'b0;
            default:                                  p.is_reg_write = !p.exception;
        endcase
        p.rs1_data = expected_operand(ins[19:15]);
        p.rs2_data = expected_operand(ins[24:20]);
        return p;
    endfunction

    function automatic rv_pipe_pkg::fetch_pkt_t random_packet();
        rv_pipe_pkg::fetch_pkt_t f;
        rv_isa_pkg::opcode_e     op;
        logic [4:0]              raw;
        int                      kind;
        kind = $urandom_range(0, 9);   // 0 fault, 1 compressed, 2 unknown opcode
        op = op.first();
        repeat ($urandom_range(0, op.num() - 1)) op = op.next();
        raw = op;
        if (kind == 2) begin
            raw = 5'($urandom);
            while (opcode_listed(raw))
                raw = raw + 5'd1;
        end
        f.valid       = 1'b1;
        f.fetch_fault = (kind == 0);
        f.instr       = $urandom;
        f.pc          = $urandom;
        f.next_pc     = f.pc + 32'd4;
        f.instr[6:2]  = raw;
        f.instr[1:0]  = (kind == 1) ? 2'($urandom_range(0, 2)) : 2'b11;
        // steer sources onto the bypassed indices
        if ($urandom_range(0, 2) == 0)
            f.instr[19:15] = exec_bypass.idx;
        if ($urandom_range(0, 2) == 0)
            f.instr[24:20] = wb.idx;
        return f;
    endfunction

    // reference model and scoreboard sampled mid-cycle
    always @(negedge clk) begin : monitor
        rv_pipe_pkg::decode_pkt_t exp_pkt;
        logic accept;
        if (!rst_n) begin
            exp_q.delete();
            for (int i = 0; i < rv_isa_pkg::reg_count; i++)
                shadow[i] = '0;
            {prev_hold, prev_flush, prev_direct, prev_capture, prev_stall} = '0;
            fetch_taken = 1'b1;
        end else begin
            accept = fetch_in.valid && !stall_prev;
            if (prev_hold)
                assert (dec_out === prev_dec) else fail_run($sformatf(
                    "CHECK FAILED at %0t: dec_out changed while stalled", $time));
            if (prev_flush)
                assert (!dec_out.valid && !stall_prev) else fail_run($sformatf(
                    "CHECK FAILED at %0t: state not cleared after flush", $time));
            if (prev_direct)
                assert (dec_out === direct_pkt) else fail_run($sformatf(
                    "CHECK FAILED at %0t: accepted packet not on dec_out one cycle later",
                    $time));
            assert (!(stall_prev && !prev_stall) || prev_capture) else fail_run($sformatf(
                "CHECK FAILED at %0t: stall_prev rose without a captured packet", $time));
            assert (!prev_capture || stall_prev) else fail_run($sformatf(
                "CHECK FAILED at %0t: captured packet but stall_prev low", $time));
            if (dec_out.valid && !next_stalled) begin
                assert (exp_q.size() > 0) else fail_run($sformatf(
                    "CHECK FAILED at %0t: unexpected packet pc %h", $time, dec_out.pc));
                exp_pkt = exp_q.pop_front();
                assert (dec_out === exp_pkt) else fail_run($sformatf(
                    "CHECK FAILED at %0t: got %h expected %h", $time, dec_out, exp_pkt));
                n_checked++;
            end
            if (flush) begin
                exp_q.delete();
            end else if (accept) begin
                direct_pkt = expected_decode(fetch_in);
                exp_q.push_back(direct_pkt);
            end
            if (wb.valid && wb.idx != 5'd0)
                shadow[wb.idx] = wb.data;
            prev_dec     = dec_out;
            prev_hold    = next_stalled && !flush;
            prev_flush   = flush;
            prev_stall   = stall_prev;
            prev_capture = accept && next_stalled && !flush;
            prev_direct  = accept && !next_stalled && !flush;
            fetch_taken  = !stall_prev;
        end
    end

    task automatic step_cycle(input logic fetching);
        @(posedge clk);
        #5;
        if (fetch_taken) begin
            if (fetching && $urandom_range(0, 3) != 0)
                fetch_in = random_packet();
            else
                fetch_in.valid = 1'b0;
        end
        next_stalled = ($urandom_range(0, 99) < stall_pct);
        flush        = fetching && ($urandom_range(0, 99) < 3);
    endtask

    task automatic drain_queue();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || fetch_in.valid) begin
            if (cycles == 200)
                fail_run("the decode front end did not drain within 200 cycles");
            step_cycle(1'b0);
            cycles++;
        end
    endtask

    task automatic fill_registers(input int count);
        for (int i = 0; i < count; i++) begin
            step_cycle(1'b0);
            wb.valid = 1'b1;
            wb.idx   = 5'($urandom);
            wb.data  = $urandom;
        end
    endtask

    // held for a whole burst so the operands stay predictable
    task automatic new_bypasses();
        exec_bypass.valid = ($urandom_range(0, 1) == 1);
        exec_bypass.idx   = 5'($urandom);
        exec_bypass.data  = $urandom;
        wb.valid          = ($urandom_range(0, 1) == 1);
        wb.idx            = 5'($urandom);
        wb.data           = $urandom;
        if ($urandom_range(0, 3) == 0)
            wb.idx = exec_bypass.idx;
        if ($urandom_range(0, 5) == 0)
            exec_bypass.idx = 5'd0;
    endtask

    initial begin
        int burst_len;
        void'($urandom(14170));
        rst_n        = 1'b0;
        flush        = 1'b0;
        next_stalled = 1'b0;
        fetch_in     = '0;
        exec_bypass  = '0;
        wb           = '0;
        stall_pct    = 0;
        n_checked    = 0;
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        assert (!stall_prev && !dec_out.valid) else fail_run($sformatf(
            "CHECK FAILED at %0t: outputs not idle after reset", $time));

        // every register through both read ports while still at reset value
        for (int r = 1; r < rv_isa_pkg::reg_count; r++) begin
            @(posedge clk);
            #5;
            fetch_in = random_packet();
            fetch_in.instr[19:15] = 5'(r);
            fetch_in.instr[24:20] = 5'(rv_isa_pkg::reg_count - r);
        end
        drain_queue();

        for (int phase = 0; phase < 40; phase++) begin
            stall_pct = (phase % 4) * 15;
            if (phase % 3 == 0)
                fill_registers(8 + $urandom_range(0, 16));
            new_bypasses();
            burst_len = 40 + $urandom_range(0, 40);
            for (int i = 0; i < burst_len; i++)
                step_cycle(1'b1);
            drain_queue();
        end

        if (n_checked < 500) begin
            fail_run($sformatf("only %0d packets reached execute", n_checked));
        end else begin
            $display("checked %0d packets", n_checked);
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_decode_front.f */
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_skid_stage.sv
rv_regfile.sv
rv_decode_stage.sv
rv_decode_front.sv
tb_rv_decode_front.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_decode_front \
    -f rv_decode_front.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
